// File: src/packetPkg.sv
`default_nettype none

package packetPkg;

    // every header word is one of these
    localparam int wordWidth = 16;

    typedef logic [wordWidth-1:0] word_t;

    // over-the-air packet type codes
    typedef enum logic [2:0] {
        pktHb      = 3'd0,
        pktChe     = 3'd1,
        pktInv     = 3'd2,
        pktMr      = 3'd3,
        pktCht     = 3'd4,
        pktData    = 3'd5,
        pktSos     = 3'd6,
        pktInvalid = 3'd7
    } pktType_t;

    // fields of the packet handed over by the packet filter
    typedef struct packed {
        pktType_t packetType;
        word_t    sourceId;
        word_t    sourceHops;
        word_t    qValue;
        word_t    energyLeft;
        word_t    hopsFromCh;
        word_t    chosenCh;
    } rxPacket_t;

    // outgoing header, field order as packed for transmission
    typedef struct packed {
        word_t    sourceId;
        word_t    destinationId;
        pktType_t packetType;
        word_t    sourceHops;
        word_t    qValue;
        word_t    energyLeft;
        word_t    chosenCh;
        word_t    hopsFromCh;
        word_t    timeslot;
    } pktHeader_t;

    // which rule produced the outgoing type
    typedef enum logic [2:0] {
        originNone,
        originHbRipple,
        originInvRipple,
        originInvOwn,
        originTimer,
        originForward,
        originOwnData
    } origin_t;

    // header after reset, also sent when no rule matches
    localparam pktHeader_t resetHeader = '{
        sourceId:      16'hFFFF,
        destinationId: 16'hFFFF,
        packetType:    pktInvalid,
        sourceHops:    16'hFFFF,
        qValue:        16'h0000,
        energyLeft:    16'h0000,
        chosenCh:      16'h0000,
        hopsFromCh:    16'hFFFF,
        timeslot:      16'h0000
    };

endpackage

`default_nettype wire

// File: src/nodePkg.sv
`default_nettype none

package nodePkg;

    // own node state from the node info block
    typedef struct packed {
        packetPkg::word_t myNodeId;
        packetPkg::word_t hopsFromSink;
        packetPkg::word_t myQValue;
        packetPkg::word_t myEnergy;
        packetPkg::word_t timeslot;
        // cluster head picked during cluster formation
        packetPkg::word_t chosenCh;
        packetPkg::word_t hopsFromCh;
        // next hop towards the sink
        packetPkg::word_t chosenHop;
        // 1 = cluster head
        logic             role;
        logic             lowEnergy;
    } nodeInfo_t;

    // idle cycles before the membership or timeslot wait runs out
    localparam packetPkg::word_t timeoutReload = 16'd10;

    // invitations ripple only below this hop count
    localparam packetPkg::word_t maxInvHops = 16'd4;

    localparam packetPkg::word_t sinkId = 16'h0000;
    localparam packetPkg::word_t broadcastId = 16'hFFFF;

endpackage

`default_nettype wire

// File: src/rewardFsm.sv
`timescale 1ns/100ps
`default_nettype none

module rewardFsm (
    input  wire logic                clk,
    input  wire logic                nrst,
    input  wire logic                en,
    input  wire logic                expired,
    input  wire logic                okToSend,
    input  wire packetPkg::pktType_t selType,
    output logic                     capture,
    output logic                     timerCause,
    output logic                     hbLock,
    output logic                     busyIdle,
    output logic                     rewardDone
);

    typedef enum logic [1:0] {
        stIdle,
        stProcess,
        stDone
    } state_t;

    state_t state;
    logic   start;
    logic   complete;

    // job starts on en or on a timer expiry
    assign start = (state == stIdle) && (en || expired);
    // okToSend accepts the held header
    assign complete = (state == stDone) && okToSend;

    assign capture = (state == stProcess);
    assign busyIdle = (state == stIdle);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state <= stProcess;
                    end
                end
                // single cycle, header gets loaded here
                stProcess: begin
                    state <= stDone;
                end
                // hold until the MAC takes the header
                stDone: begin
                    if (okToSend) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // en wins over the timer when both arrive together
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            timerCause <= 1'b0;
        end else if (start) begin
            timerCause <= expired && !en;
        end
    end

    // selType is still the sent type at completion since inputs are held
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hbLock <= 1'b0;
        end else if (complete) begin
            if (selType == packetPkg::pktHb) begin
                hbLock <= 1'b1;
            end else if (selType == packetPkg::pktData) begin
                hbLock <= 1'b0;
            end
        end
    end

    // one-cycle pulse after acceptance
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rewardDone <= 1'b0;
        end else begin
            rewardDone <= complete;
        end
    end

endmodule

`default_nettype wire

// File: src/waitTimer.sv
`timescale 1ns/100ps
`default_nettype none

module waitTimer (
    input  wire logic clk,
    input  wire logic nrst,
    input  wire logic busyIdle,
    input  wire logic en,
    input  wire logic hbLock,
    output logic      expired
);

    packetPkg::word_t count;
    logic             hold;

    // counting only while idle, not enabled and heartbeat locked
    assign hold = !busyIdle || en || !hbLock;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= nodePkg::timeoutReload;
        end else if (hold) begin
            count <= nodePkg::timeoutReload;
        end else if (count != '0) begin
            count <= count - 16'd1;
        end
    end

    // role decides MR or CHT once this fires
    assign expired = (count == '0);

endmodule

`default_nettype wire

// File: src/packetSelect.sv
`timescale 1ns/100ps
`default_nettype none

module packetSelect (
    input  wire nodePkg::nodeInfo_t   node,
    input  wire packetPkg::rxPacket_t rx,
    input  wire logic                 iHaveData,
    input  wire logic                 iAmDestination,
    input  wire logic                 timerCause,
    input  wire logic                 hbLock,
    output packetPkg::pktType_t       selType,
    output packetPkg::origin_t        origin
);

    logic                rxIsData;
    packetPkg::pktType_t dataType;

    assign rxIsData = (rx.packetType == packetPkg::pktData) ||
                      (rx.packetType == packetPkg::pktSos);
    // low energy turns any data send into SOS
    assign dataType = node.lowEnergy ? packetPkg::pktSos : packetPkg::pktData;

    // first match wins
    always_comb begin
        if (timerCause && !node.role) begin
            // member ran out of invitation wait
            selType = packetPkg::pktMr;
            origin = packetPkg::originTimer;
        end else if (timerCause && node.role) begin
            // head ran out of membership wait
            selType = packetPkg::pktCht;
            origin = packetPkg::originTimer;
        end else if (rx.packetType == packetPkg::pktHb && !hbLock) begin
            selType = packetPkg::pktHb;
            origin = packetPkg::originHbRipple;
        end else if (rx.packetType == packetPkg::pktInv &&
                     rx.hopsFromCh < nodePkg::maxInvHops) begin
            selType = packetPkg::pktInv;
            origin = packetPkg::originInvRipple;
        end else if (node.role && hbLock) begin
            // head advertises itself
            selType = packetPkg::pktInv;
            origin = packetPkg::originInvOwn;
        end else if (iAmDestination && rxIsData) begin
            selType = dataType;
            origin = packetPkg::originForward;
        end else if (iHaveData) begin
            selType = dataType;
            origin = packetPkg::originOwnData;
        end else begin
            selType = packetPkg::pktInvalid;
            origin = packetPkg::originNone;
        end
    end

endmodule

`default_nettype wire

// File: src/headerPacker.sv
`timescale 1ns/100ps
`default_nettype none

module headerPacker (
    input  wire logic                 clk,
    input  wire logic                 nrst,
    input  wire logic                 capture,
    input  wire packetPkg::pktType_t  selType,
    input  wire packetPkg::origin_t   origin,
    input  wire nodePkg::nodeInfo_t   node,
    input  wire packetPkg::rxPacket_t rx,
    output packetPkg::pktHeader_t     header,
    output logic                      txSetting
);

    packetPkg::pktHeader_t nextHeader;
    packetPkg::word_t      dataDest;
    logic                  nextTx;

    // next to the sink talk to it directly
    assign dataDest = (node.hopsFromSink == 16'd1) ? nodePkg::sinkId : node.chosenHop;

    // MR to a far head needs four-hop power, everything else one-hop
    assign nextTx = (selType == packetPkg::pktMr) && (node.hopsFromCh > 16'd1);

    always_comb begin
        // own values unless the origin says otherwise
        nextHeader = '{
            sourceId:      node.myNodeId,
            destinationId: nodePkg::broadcastId,
            packetType:    selType,
            sourceHops:    node.hopsFromSink,
            qValue:        node.myQValue,
            energyLeft:    node.myEnergy,
            chosenCh:      node.chosenCh,
            hopsFromCh:    node.hopsFromCh,
            timeslot:      node.timeslot
        };
        case (origin)
            packetPkg::originHbRipple: begin
                nextHeader.sourceId = rx.sourceId;
                nextHeader.sourceHops = node.hopsFromSink + 16'd1;
                nextHeader.qValue = rx.qValue;
                nextHeader.chosenCh = '0;
                nextHeader.hopsFromCh = 16'hFFFF;
            end
            packetPkg::originInvRipple: begin
                // pass the head's details one hop further
                nextHeader.sourceId = rx.sourceId;
                nextHeader.qValue = rx.qValue;
                nextHeader.energyLeft = rx.energyLeft;
                nextHeader.hopsFromCh = rx.hopsFromCh + 16'd1;
                nextHeader.chosenCh = rx.chosenCh;
            end
            packetPkg::originInvOwn: begin
                nextHeader.hopsFromCh = 16'd1;
                nextHeader.chosenCh = node.myNodeId;
            end
            packetPkg::originTimer: begin
                if (selType == packetPkg::pktCht) begin
                    nextHeader.chosenCh = node.myNodeId;
                    nextHeader.hopsFromCh = '0;
                end else begin
                    // membership request goes to the chosen head
                    nextHeader.destinationId = node.chosenCh;
                end
            end
            packetPkg::originForward: begin
                nextHeader.sourceId = rx.sourceId;
                nextHeader.sourceHops = rx.sourceHops;
                nextHeader.qValue = rx.qValue;
                nextHeader.energyLeft = rx.energyLeft;
                nextHeader.chosenCh = rx.chosenCh;
                nextHeader.hopsFromCh = rx.hopsFromCh;
                nextHeader.destinationId = dataDest;
            end
            packetPkg::originOwnData: begin
                nextHeader.destinationId = dataDest;
            end
            default: begin
                nextHeader = packetPkg::resetHeader;
            end
        endcase
    end

    // loaded once per job, held through done
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            header <= packetPkg::resetHeader;
            txSetting <= 1'b0;
        end else if (capture) begin
            header <= nextHeader;
            txSetting <= nextTx;
        end
    end

endmodule

`default_nettype wire

// File: src/rewardBlock.sv
`timescale 1ns/100ps
`default_nettype none

module rewardBlock (
    input  wire logic                 clk,
    input  wire logic                 nrst,
    input  wire logic                 en,
    input  wire logic                 iHaveData,
    input  wire logic                 iAmDestination,
    input  wire logic                 okToSend,
    input  wire nodePkg::nodeInfo_t   node,
    input  wire packetPkg::rxPacket_t rx,
    output packetPkg::pktHeader_t     header,
    output logic                      txSetting,
    output logic                      rewardDone
);

    logic                capture;
    logic                timerCause;
    logic                hbLock;
    logic                busyIdle;
    logic                expired;
    packetPkg::pktType_t selType;
    packetPkg::origin_t  origin;

    // job sequencing and heartbeat lock
    rewardFsm fsm (
        .clk        (clk),
        .nrst       (nrst),
        .en         (en),
        .expired    (expired),
        .okToSend   (okToSend),
        .selType    (selType),
        .capture    (capture),
        .timerCause (timerCause),
        .hbLock     (hbLock),
        .busyIdle   (busyIdle),
        .rewardDone (rewardDone)
    );

    // MR / CHT wait
    waitTimer timer (
        .clk      (clk),
        .nrst     (nrst),
        .busyIdle (busyIdle),
        .en       (en),
        .hbLock   (hbLock),
        .expired  (expired)
    );

    packetSelect select (
        .node           (node),
        .rx             (rx),
        .iHaveData      (iHaveData),
        .iAmDestination (iAmDestination),
        .timerCause     (timerCause),
        .hbLock         (hbLock),
        .selType        (selType),
        .origin         (origin)
    );

    // header register, loads on capture
    headerPacker packer (
        .clk       (clk),
        .nrst      (nrst),
        .capture   (capture),
        .selType   (selType),
        .origin    (origin),
        .node      (node),
        .rx        (rx),
        .header    (header),
        .txSetting (txSetting)
    );

endmodule

`default_nettype wire

// File: dv/rewardBlock_props.sv
`timescale 1ns/100ps
`default_nettype none

module rewardFsmProps (
    input wire logic                  clk,
    input wire logic                  nrst,
    input wire logic                  en,
    input wire logic                  expired,
    input wire logic                  okToSend,
    input wire logic                  capture,
    input wire logic                  busyIdle,
    input wire logic                  rewardDone,
    input wire packetPkg::pktHeader_t header
);

    logic start;
    logic inDone;

    // accepted start in idle
    assign start = busyIdle && (en || expired);
    // neither idle nor process
    assign inDone = !busyIdle && !capture;

    startToCapture: assert property (@(posedge clk) disable iff (!nrst) start |=> capture)
        else $error("capture missing one cycle after a job start");

    captureFromStart: assert property (@(posedge clk) disable iff (!nrst)
        capture |-> $past(start))
        else $error("capture without a job start");

    pulseWidth: assert property (@(posedge clk) disable iff (!nrst) rewardDone |=> !rewardDone)
        else $error("rewardDone longer than one cycle");

    pulseCause: assert property (@(posedge clk) disable iff (!nrst)
        rewardDone |-> $past(inDone && okToSend))
        else $error("rewardDone without okToSend in done");

    // the MAC may read the header in any done cycle
    headerHeld: assert property (@(posedge clk) disable iff (!nrst)
        inDone |=> $stable(header))
        else $error("header changed while in done");

endmodule

bind rewardFsm rewardFsmProps props (
    .clk        (clk),
    .nrst       (nrst),
    .en         (en),
    .expired    (expired),
    .okToSend   (okToSend),
    .capture    (capture),
    .busyIdle   (busyIdle),
    .rewardDone (rewardDone),
    .header     (packer.header)
);

`default_nettype wire

// File: dv/rewardBlockTb.sv
`timescale 1ns/100ps
`default_nettype none

module rewardBlockTb;

    // wide enough for a whole header
    typedef logic [135:0] cmp_t;

    logic                  clk;
    logic                  nrst;
    logic                  en;
    logic                  iHaveData;
    logic                  iAmDestination;
    logic                  okToSend;
    nodePkg::nodeInfo_t    node;
    packetPkg::rxPacket_t  rx;
    packetPkg::pktHeader_t header;
    logic                  txSetting;
    logic                  rewardDone;

    logic [15:0]           lfsr;
    // model of the heartbeat lock
    logic                  lockModel;
    packetPkg::pktHeader_t expHeader;
    logic                  expTx;
    int                    checks;
    int                    errors;
    int                    timeouts;

    rewardBlock DUT (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .iHaveData      (iHaveData),
        .iAmDestination (iAmDestination),
        .okToSend       (okToSend),
        .node           (node),
        .rx             (rx),
        .header         (header),
        .txSetting      (txSetting),
        .rewardDone     (rewardDone)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit
    function automatic logic randBit();
        lfsr = lfsrStep(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], randBit()};
        end
        return v;
    endfunction

    // header after reset and for the no-match case
    function automatic packetPkg::pktHeader_t idleHeader();
        return '{
            sourceId:      16'hFFFF,
            destinationId: 16'hFFFF,
            packetType:    packetPkg::pktInvalid,
            sourceHops:    16'hFFFF,
            qValue:        16'h0000,
            energyLeft:    16'h0000,
            chosenCh:      16'h0000,
            hopsFromCh:    16'hFFFF,
            timeslot:      16'h0000
        };
    endfunction

    task automatic compare(input string name, input cmp_t got, input cmp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic drawInputs();
        logic [15:0] t;
        t = randBits(3);
        rx.packetType = packetPkg::pktType_t'(t[2:0]);
        rx.sourceId = randBits(16);
        rx.sourceHops = randBits(16);
        rx.qValue = randBits(16);
        rx.energyLeft = randBits(16);
        // small hop counts so the limit of 4 gets hit both ways
        rx.hopsFromCh = randBits(3);
        rx.chosenCh = randBits(16);
        node.myNodeId = randBits(16);
        // 1 often enough for the sink rule
        node.hopsFromSink = randBits(2);
        node.myQValue = randBits(16);
        node.myEnergy = randBits(16);
        node.timeslot = randBits(16);
        node.chosenCh = randBits(16);
        node.hopsFromCh = randBits(2);
        node.chosenHop = randBits(16);
        node.role = randBit();
        node.lowEnergy = randBit();
        iHaveData = randBit();
        iAmDestination = randBit();
    endtask

    // priority list and field rules applied to the held inputs
    task automatic predict(input logic fromTimer);
        packetPkg::pktType_t dataKind;
        packetPkg::word_t    dataDest;
        logic                rxData;
        dataKind = node.lowEnergy ? packetPkg::pktSos : packetPkg::pktData;
        dataDest = (node.hopsFromSink == 16'd1) ? nodePkg::sinkId : node.chosenHop;
        rxData = (rx.packetType == packetPkg::pktData) || (rx.packetType == packetPkg::pktSos);
        // own values unless a rule below overrides them
        expHeader.sourceId = node.myNodeId;
        expHeader.destinationId = nodePkg::broadcastId;
        expHeader.sourceHops = node.hopsFromSink;
        expHeader.qValue = node.myQValue;
        expHeader.energyLeft = node.myEnergy;
        expHeader.chosenCh = node.chosenCh;
        expHeader.hopsFromCh = node.hopsFromCh;
        expHeader.timeslot = node.timeslot;
        if (fromTimer && !node.role) begin
            // membership request to the chosen head
            expHeader.packetType = packetPkg::pktMr;
            expHeader.destinationId = node.chosenCh;
        end else if (fromTimer) begin
            expHeader.packetType = packetPkg::pktCht;
            expHeader.chosenCh = node.myNodeId;
            expHeader.hopsFromCh = 16'h0000;
        end else if (rx.packetType == packetPkg::pktHb && !lockModel) begin
            expHeader.packetType = packetPkg::pktHb;
            expHeader.sourceId = rx.sourceId;
            expHeader.sourceHops = node.hopsFromSink + 16'd1;
            expHeader.qValue = rx.qValue;
            expHeader.chosenCh = 16'h0000;
            expHeader.hopsFromCh = 16'hFFFF;
        end else if (rx.packetType == packetPkg::pktInv &&
                     rx.hopsFromCh < nodePkg::maxInvHops) begin
            expHeader.packetType = packetPkg::pktInv;
            expHeader.sourceId = rx.sourceId;
            expHeader.qValue = rx.qValue;
            expHeader.energyLeft = rx.energyLeft;
            expHeader.chosenCh = rx.chosenCh;
            expHeader.hopsFromCh = rx.hopsFromCh + 16'd1;
        end else if (node.role && lockModel) begin
            // head's own invitation
            expHeader.packetType = packetPkg::pktInv;
            expHeader.chosenCh = node.myNodeId;
            expHeader.hopsFromCh = 16'd1;
        end else if (iAmDestination && rxData) begin
            expHeader = '{
                sourceId:      rx.sourceId,
                destinationId: dataDest,
                packetType:    dataKind,
                sourceHops:    rx.sourceHops,
                qValue:        rx.qValue,
                energyLeft:    rx.energyLeft,
                chosenCh:      rx.chosenCh,
                hopsFromCh:    rx.hopsFromCh,
                timeslot:      node.timeslot
            };
        end else if (iHaveData) begin
            expHeader.packetType = dataKind;
            expHeader.destinationId = dataDest;
        end else begin
            expHeader = idleHeader();
        end
        expTx = (expHeader.packetType == packetPkg::pktMr) && (node.hopsFromCh > 16'd1);
    endtask

    task automatic followLock();
        if (expHeader.packetType == packetPkg::pktHb) begin
            lockModel = 1'b1;
        end else if (expHeader.packetType == packetPkg::pktData) begin
            lockModel = 1'b0;
        end
    endtask

    // counts cycles until rewardDone within a bounded wait
    task automatic waitForDone(input int limit, output int cycles);
        logic found;
        cycles = 0;
        found = 1'b0;
        while (!found && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            found = rewardDone;
        end
        if (!found) begin
            timeouts++;
            $display("Timeout: rewardDone did not arrive within %0d cycles", limit);
        end
    endtask

    task automatic checkHeld();
        compare("header", cmp_t'(header), cmp_t'(expHeader));
        compare("txSetting", cmp_t'(txSetting), cmp_t'(expTx));
    endtask

    // job started by en with okToSend after delay cycles in done
    task automatic runJob(input int delay);
        int cycles;
        predict(1'b0);
        en = 1'b1;
        @(posedge clk);
        #1;
        en = 1'b0;
        @(posedge clk);
        #1;
        // in done from this edge with the header loaded
        for (int i = 0; i <= delay; i++) begin
            checkHeld();
            compare("rewardDone", cmp_t'(rewardDone), cmp_t'(0));
            if (i < delay) begin
                // en has no effect in done
                en = randBit();
                @(posedge clk);
                #1;
            end
        end
        en = 1'b0;
        okToSend = 1'b1;
        waitForDone(8, cycles);
        okToSend = 1'b0;
        compare("rewardDone delay", cmp_t'(cycles), cmp_t'(1));
        checkHeld();
        followLock();
    endtask

    // job started by the wait timer once the lock is set
    task automatic runTimerJob();
        int cycles;
        predict(1'b1);
        en = 1'b0;
        okToSend = 1'b1;
        waitForDone(40, cycles);
        okToSend = 1'b0;
        checkHeld();
        followLock();
    endtask

    initial begin
        lfsr = 16'd11236;
        checks = 0;
        errors = 0;
        timeouts = 0;
        lockModel = 1'b0;
        nrst = 1'b0;
        en = 1'b0;
        okToSend = 1'b0;
        iHaveData = 1'b0;
        iAmDestination = 1'b0;
        node = '0;
        rx = '0;
        expHeader = idleHeader();
        expTx = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        nrst = 1'b1;
        compare("header", cmp_t'(header), cmp_t'(idleHeader()));
        compare("txSetting", cmp_t'(txSetting), cmp_t'(0));
        compare("rewardDone", cmp_t'(rewardDone), cmp_t'(0));

        // heartbeat ripple and then the lockout
        drawInputs();
        rx.packetType = packetPkg::pktHb;
        node.role = 1'b0;
        iHaveData = 1'b0;
        iAmDestination = 1'b0;
        runJob(0);
        runJob(1);
        // four-hop MR to a far head
        node.hopsFromCh = 16'd3;
        runTimerJob();
        node.role = 1'b1;
        runTimerJob();
        // locked head ripples below 4 hops and invites on its own above
        rx.packetType = packetPkg::pktInv;
        rx.hopsFromCh = 16'd3;
        runJob(2);
        rx.hopsFromCh = 16'd7;
        runJob(0);
        // own data clears the lock so the heartbeat goes out again
        node.role = 1'b0;
        node.lowEnergy = 1'b0;
        iHaveData = 1'b1;
        runJob(1);
        rx.packetType = packetPkg::pktHb;
        iHaveData = 1'b0;
        runJob(3);

        // random mix with timer jobs only when locked
        for (int n = 0; n < 80; n++) begin
            drawInputs();
            if (lockModel && randBit()) begin
                runTimerJob();
            end else begin
                runJob(int'(randBits(3)));
            end
        end

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/packetPkg.sv
src/nodePkg.sv
src/rewardFsm.sv
src/waitTimer.sv
src/packetSelect.sv
src/headerPacker.sv
src/rewardBlock.sv
dv/rewardBlock_props.sv
dv/rewardBlockTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= rewardBlockTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
